// File: tune_recognizer_top.f
+incdir+common
common/note_pkg.sv
pitch/pitch_meter.sv
pitch/note_detector.sv
verilog/song_tracker.sv
verilog/status_display.sv
verilog/tune_recognizer_top.sv
tb/tb_tune_recognizer.sv

// File: tb/tune_stimulus.txt
// period  duration  note_seg  tune0_seg  tune1_seg  leds   (all hex, one tone per line)
// Period and duration in clock cycles, period 0 is silence, segments abcdefgh
0218 1b58 ef 60 fc 0   // A# 536, tune 0 step 1
0353 1b58 7a da fc 0   // D 851, step 2
0218 1b58 ef f2 fc 0   // A#, step 3
0353 1b58 7a 66 fc 0   // D, step 4
0324 1b58 7b b6 fc 0   // D# 804, step 5
0353 1b58 7a be fc 0   // D, step 6
03bc 1b58 9c e0 fc 0   // C 956, step 7
0238 1b58 ee fe fc 0   // A 568, step 8
03bc 1b58 9c e6 fc 0   // C, step 9
0238 1b58 ee ee fc 0   // A, step a
03bc 1b58 9c 3e fc 0   // C, step b
0353 1b58 7a 9c fc 0   // D, step c
03bc 1b58 9c 7a fc 0   // C, step d
0218 1b58 ef 9e fc 0   // A#, step e
027e 1b58 bc c6 60 4   // G 638, tune 0 done, tune 1 also takes its first G
02f6 1b58 9e c6 60 4   // E 758, wrong note
027e 1b58 bc c6 60 4   // G, tune 1 waits for C
03bc 1b58 9c c6 da 4   // C, tune 1 step 2
0324 1b58 7b c6 f2 4   // D#, step 3
0353 1b58 7a c6 66 4   // D, step 4
03bc 1b58 9c c6 b6 4   // C, step 5
0324 1b58 7b c6 be 4   // D#, step 6
03bc 1b58 9c c6 e0 4   // C, step 7
0353 1b58 7a c6 fe 4   // D, step 8
03bc 1b58 9c c6 e6 4   // C, step 9
025a 1b58 bd c6 ee 4   // G# 602, step a
0218 1b58 ef c6 3e 4   // A#, step b
027e 1b58 bc c6 9c 4   // G, step c
03bc 1b58 9c c6 7a 4   // C, step d
0324 1b58 7b c6 9e 4   // D#, step e
0353 1b58 7a c6 c6 7   // D, tune 1 done
1388 3e80 02 c6 c6 7   // 5000 cycles, below the lowest band
0000 07d0 02 c6 c6 7   // Silence

// File: tb/tb_tune_recognizer.sv
`timescale 1ns/1ps

`include "note_config.svh"

module tb_tune_recognizer;

    import note_pkg::*;

    localparam int MAX_LINES   = 64;
    localparam int SCAN_PERIOD = 1 << `NOTE_SCAN_W;

    logic                          clk;
    logic                          rst;
    logic signed [`NOTE_MIC_W-1:0] i_mic;
    seg_t                          o_abcdefgh;
    logic [3:0]                    o_digit;
    led_t                          o_led;

    logic [15:0] stim_mem [0:6*MAX_LINES-1];  // Six fields per tone
    logic [15:0] tone_period;                 // Zero means silence
    logic [31:0] lfsr_state;
    int          n_lines;
    int          n_tests;
    int          n_checks;
    int          n_errors;
    int          cycle_count;
    int          cycle_limit;

    tune_recognizer_top dut0
    (
        .clk        (clk),
        .rst        (rst),
        .i_mic      (i_mic),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit),
        .o_led      (o_led)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------
    // Microphone square wave with noisy magnitude

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial
    begin : tone_gen
        logic [15:0]             cur_period;
        logic [`NOTE_MIC_W-2:0] mag;
        int                      phase;
        int                      b;
        i_mic      = '0;
        lfsr_state = 32'hab1f5965;
        cur_period = '0;
        mag        = '0;
        phase      = 0;
        forever
        begin
            @(posedge clk);
            if (tone_period != cur_period)
            begin
                cur_period = tone_period;  // New tone opens on its positive half
                phase      = 0;
            end
            for (b = 0; b < `NOTE_MIC_W - 1; b++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                mag        = {mag[`NOTE_MIC_W-3:0], lfsr_state[0]};
            end
            if (cur_period != 0 && phase < cur_period / 2)
                i_mic <= {1'b0, mag};
            else
                i_mic <= {1'b1, mag};  // Silence stays below zero
            phase = (phase + 1 >= cur_period) ? 0 : phase + 1;
        end
    end

    initial
    begin : watchdog
        cycle_count = 0;
        @(posedge clk);
        while (cycle_limit == 0 || cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Compare tasks

    task automatic check_seg(input seg_t got, input seg_t exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_led(input led_t got, input led_t exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_digit(input logic [3:0] got, input logic [3:0] exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_digit_change(input logic [3:0] prev, output logic [3:0] cur);
        int waited;
        waited = 0;
        cur    = o_digit;
        while (cur === prev && waited <= SCAN_PERIOD)
        begin
            @(negedge clk);
            cur = o_digit;
            waited++;
        end
        if (cur === prev)
        begin
            n_errors++;
            $display("Digit select stuck at %b for %0d cycles at %0t", prev, waited, $time);
        end
    endtask

    // Walks one full scan and checks every digit against the file
    task automatic check_tone(input seg_t exp_note, input seg_t exp_t0, input seg_t exp_t1,
                              input led_t exp_led);
        logic [3:0] prev;
        logic [3:0] cur;
        check_led(o_led, exp_led, "LEDs");
        prev = o_digit;
        repeat (4)
        begin
            wait_digit_change(prev, cur);
            check_digit(cur, {prev[2:0], prev[3]}, "digit select");
            case (cur)
                4'b1000: check_seg(o_abcdefgh, exp_note, "note digit");
                4'b0010: check_seg(o_abcdefgh, exp_t0, "tune 0 digit");
                4'b0001: check_seg(o_abcdefgh, exp_t1, "tune 1 digit");
                default: check_seg(o_abcdefgh, SEG_BLANK, "blank digit");
            endcase
            prev = cur;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, n_errors - errs_before);
    endtask

    // ----------------------------------------------------------
    // Main sequence

    initial
    begin : main
        logic [3:0] prev;
        logic [3:0] cur;
        int         total;
        int         errs_before;
        int         waited;
        int         i;
        rst         = 1'b1;
        tone_period = '0;
        n_tests     = 0;
        n_checks    = 0;
        n_errors    = 0;
        cycle_limit = 0;

        $readmemh("tb/tune_stimulus.txt", stim_mem);
        n_lines = 0;
        total   = 3;  // Reset cycles
        while (n_lines < MAX_LINES && (^stim_mem[6*n_lines+1]) !== 1'bx
               && stim_mem[6*n_lines+1] != 0)
        begin
            total += stim_mem[6*n_lines+1];
            n_lines++;
        end
        cycle_limit = total + total / 5;
        if (n_lines == 0)
        begin
            n_errors++;
            $display("Stimulus file holds no tone lines");
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // Outputs stay dark until the first strobe
        errs_before = n_errors;
        check_digit(o_digit, 4'b0000, "digit select after reset");
        waited = 0;
        while (o_digit === 4'b0000 && waited <= SCAN_PERIOD)
        begin
            check_seg(o_abcdefgh, SEG_BLANK, "segments before first strobe");
            check_led(o_led, '0, "LEDs before first strobe");
            @(negedge clk);
            waited++;
        end
        if (o_digit === 4'b0000)
        begin
            n_errors++;
            $display("No scan strobe arrived after reset");
        end
        report_test("reset", errs_before);

        errs_before = n_errors;
        prev        = o_digit;
        if (prev == 4'b0000 || (prev & (prev - 4'd1)) != 4'b0000)
        begin
            n_errors++;
            $display("First digit select %b is not one-hot", prev);
        end
        repeat (8)
        begin
            wait_digit_change(prev, cur);
            check_digit(cur, {prev[2:0], prev[3]}, "digit select rotation");
            prev = cur;
        end
        report_test("scan order", errs_before);

        for (i = 0; i < n_lines; i++)
        begin
            @(posedge clk);
            tone_period <= stim_mem[6*i];
            repeat (stim_mem[6*i+1]) @(posedge clk);
            @(negedge clk);
            errs_before = n_errors;
            check_tone(stim_mem[6*i+2][7:0], stim_mem[6*i+3][7:0], stim_mem[6*i+4][7:0],
                       stim_mem[6*i+5][2:0]);
            report_test($sformatf("tone %0d period %0d", i + 1, stim_mem[6*i]), errs_before);
        end

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog/tune_recognizer_top.sv
`timescale 1ns/1ps

`include "note_config.svh"

module tune_recognizer_top
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic signed [`NOTE_MIC_W-1:0] i_mic,
    output note_pkg::seg_t                o_abcdefgh,
    output logic [3:0]                    o_digit,
    output note_pkg::led_t                o_led
);

    import note_pkg::*;

    period_t period;                 // Cycles between crossings
    note_t   note;                   // Filtered pitch class
    step_t   steps [`NOTE_N_SONGS];

    pitch_meter u_pitch_meter
    (
        .clk      (clk),
        .rst      (rst),
        .i_mic    (i_mic),
        .o_period (period)
    );

    note_detector u_note_detector
    (
        .clk      (clk),
        .rst      (rst),
        .i_period (period),
        .o_note   (note)
    );

    // ----------------------------------------------------------
    // One tracker per tune, all fed the same note

    for (genvar s = 0; s < `NOTE_N_SONGS; s++)
    begin : g_tracker
        song_tracker #(.SONG_ID(s)) u_song_tracker
        (
            .clk    (clk),
            .rst    (rst),
            .i_note (note),
            .o_step (steps[s])
        );
    end

    status_display u_status_display
    (
        .clk        (clk),
        .rst        (rst),
        .i_note     (note),
        .i_step0    (steps[0]),
        .i_step1    (steps[1]),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit),
        .o_led      (o_led)
    );

endmodule

// File: verilog/status_display.sv
`timescale 1ns/1ps

`include "note_config.svh"

module status_display
(
    input  logic            clk,
    input  logic            rst,
    input  note_pkg::note_t i_note,
    input  note_pkg::step_t i_step0,
    input  note_pkg::step_t i_step1,
    output note_pkg::seg_t  o_abcdefgh,
    output logic [3:0]      o_digit,
    output note_pkg::led_t  o_led
);

    import note_pkg::*;

    // ----------------------------------------------------------
    // Glyph lookup

    function automatic seg_t note_glyph(input note_t n);
        seg_t g;
        g = SEG_DASH;  // No note
        for (int i = 0; i < NOTE_N_CLASSES; i++)
        begin
            if (n[NOTE_N_CLASSES - 1 - i])
                g = SEG_NOTE[i];
        end
        return g;
    endfunction

    function automatic seg_t step_glyph(input step_t s);
        if (s == STEP_DONE)
            return SEG_DONE;
        return SEG_HEX[s];
    endfunction

    // ----------------------------------------------------------
    // Scan timing

    logic [`NOTE_SCAN_W-1:0] scan_cnt;
    logic                    scan_strobe;
    logic [1:0]              idx;       // Digit currently lit
    logic [1:0]              idx_next;

    assign scan_strobe = &scan_cnt;
    assign idx_next    = idx + 2'd1;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;  // Free running
    end

    // Segment data for the digit about to be selected
    seg_t seg_next;

    always_comb
    begin
        case (idx_next)
            2'd3:    seg_next = note_glyph(i_note);
            2'd1:    seg_next = step_glyph(i_step0);  // Tune 0
            2'd0:    seg_next = step_glyph(i_step1);  // Tune 1
            default: seg_next = SEG_BLANK;
        endcase
    end

    // Select and segments change on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            idx        <= 2'd0;
            o_digit    <= 4'b0000;
            o_abcdefgh <= SEG_BLANK;
        end
        else if (scan_strobe)
        begin
            idx        <= idx_next;
            o_digit    <= 4'b0001 << idx_next;
            o_abcdefgh <= seg_next;
        end
    end

    // ----------------------------------------------------------
    // Recognition LEDs

    led_t led_next;

    always_comb
    begin
        led_next[2] = (i_step0 == STEP_DONE);
        led_next[1] = (i_step1 == STEP_DONE);
        led_next[0] = led_next[2] & led_next[1];  // Both tunes heard
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            o_led <= '0;
        else
            o_led <= led_next;
    end

endmodule

// File: verilog/song_tracker.sv
`timescale 1ns/1ps

module song_tracker
#(
    parameter int SONG_ID = 0  // Row of the tune table
)
(
    input  logic            clk,
    input  logic            rst,
    input  note_pkg::note_t i_note,
    output note_pkg::step_t o_step
);

    import note_pkg::*;

    note_t expected;  // Note wanted at the current step
    logic  hit;

    assign expected = song_note(SONG_ID, o_step);

    // Recognised state is terminal
    assign hit = (o_step != STEP_DONE) && (i_note == expected);

    // ----------------------------------------------------------
    // Step register

    // The filtered note holds for many cycles, but the next step
    // expects a different note, so one tone advances only once

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            o_step <= '0;
        else if (hit)
            o_step <= o_step + 1'b1;  // Step 14 goes to STEP_DONE
    end

endmodule

// File: pitch/note_detector.sv
`timescale 1ns/1ps

`include "note_config.svh"

module note_detector
(
    input  logic              clk,
    input  logic              rst,
    input  note_pkg::period_t i_period,
    output note_pkg::note_t   o_note
);

    import note_pkg::*;

    // ----------------------------------------------------------
    // Period bounds per pitch class

    // Period in cycles is clk_hz * 100 / freq_100, scaled by tol / 100
    function automatic period_t period_bound(
        input int unsigned freq_100,
        input int unsigned mult,
        input int unsigned tol
    );
        longint unsigned num;
        longint unsigned den;
        num = longint'(`NOTE_CLK_HZ) * tol;
        den = longint'(freq_100) * mult;
        return period_t'(num / den);
    endfunction

    function automatic logic in_band(input period_t p, input period_t lo, input period_t hi);
        return (p > lo) && (p < hi);
    endfunction

    note_t raw_note;

    for (genvar i = 0; i < NOTE_N_CLASSES; i++)
    begin : g_class
        localparam int unsigned FREQ = PITCH_FREQ_100[i];

        localparam period_t LO1 = period_bound(FREQ, 1, `NOTE_TOL_LOW);
        localparam period_t HI1 = period_bound(FREQ, 1, `NOTE_TOL_HIGH);
        localparam period_t LO2 = period_bound(FREQ, 2, `NOTE_TOL_LOW);
        localparam period_t HI2 = period_bound(FREQ, 2, `NOTE_TOL_HIGH);
        localparam period_t LO4 = period_bound(FREQ, 4, `NOTE_TOL_LOW);
        localparam period_t HI4 = period_bound(FREQ, 4, `NOTE_TOL_HIGH);

        // Three octaves fold onto one class
        assign raw_note[NOTE_N_CLASSES - 1 - i] = in_band(i_period, LO1, HI1)
                                                | in_band(i_period, LO2, HI2)
                                                | in_band(i_period, LO4, HI4);
    end

    // ----------------------------------------------------------
    // Stability filter

    note_t                     d_note;      // Raw note one cycle back
    logic [`NOTE_STABLE_W-1:0] stable_cnt;
    logic                      stable_full;

    assign stable_full = &stable_cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            d_note     <= NOTE_NONE;
            stable_cnt <= '0;
        end
        else
        begin
            d_note <= raw_note;

            if (raw_note != d_note)
                stable_cnt <= '0;                  // Any change restarts the window
            else if (!stable_full)
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // Output only moves after a full quiet window
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            o_note <= NOTE_NONE;
        else if (stable_full)
            o_note <= d_note;
    end

endmodule

// File: pitch/pitch_meter.sv
`timescale 1ns/1ps

`include "note_config.svh"

module pitch_meter
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic signed [`NOTE_MIC_W-1:0] i_mic,
    output note_pkg::period_t             o_period
);

    import note_pkg::*;

    logic    prev_sign;  // Sign of the previous sample
    logic    crossing;
    period_t count;

    // Negative to positive
    assign crossing = prev_sign & ~i_mic[`NOTE_MIC_W-1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            prev_sign <= 1'b0;
            count     <= '0;
            o_period  <= '0;
        end
        else
        begin
            prev_sign <= i_mic[`NOTE_MIC_W-1];

            if (crossing)
            begin
                o_period <= count;
                count    <= '0;
            end
            else if (count != '1)  // Hold at full scale on silence
            begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: common/note_pkg.sv
`include "note_config.svh"

package note_pkg;

    localparam int NOTE_N_CLASSES = 12;
    localparam int SONG_LEN       = 15;  // Notes per tune

    typedef logic [NOTE_N_CLASSES-1:0] note_t;  // One-hot, C in the top bit
    typedef logic [`NOTE_PERIOD_W-1:0] period_t;
    typedef logic [3:0]                step_t;
    typedef logic [7:0]                seg_t;   // abcdefgh
    typedef logic [2:0]                led_t;

    // ----------------------------------------------------------
    // Pitch classes

    localparam note_t NOTE_NONE = 12'b0000_0000_0000;
    localparam note_t NOTE_C    = 12'b1000_0000_0000;
    localparam note_t NOTE_CS   = 12'b0100_0000_0000;
    localparam note_t NOTE_D    = 12'b0010_0000_0000;
    localparam note_t NOTE_DS   = 12'b0001_0000_0000;
    localparam note_t NOTE_E    = 12'b0000_1000_0000;
    localparam note_t NOTE_F    = 12'b0000_0100_0000;
    localparam note_t NOTE_FS   = 12'b0000_0010_0000;
    localparam note_t NOTE_G    = 12'b0000_0001_0000;
    localparam note_t NOTE_GS   = 12'b0000_0000_1000;
    localparam note_t NOTE_A    = 12'b0000_0000_0100;
    localparam note_t NOTE_AS   = 12'b0000_0000_0010;
    localparam note_t NOTE_B    = 12'b0000_0000_0001;

    localparam note_t NOTE_DF = NOTE_CS;
    localparam note_t NOTE_EF = NOTE_DS;
    localparam note_t NOTE_GF = NOTE_FS;
    localparam note_t NOTE_AF = NOTE_GS;
    localparam note_t NOTE_BF = NOTE_AS;

    // Fourth octave in centi-hertz, C first
    localparam int unsigned PITCH_FREQ_100 [0:NOTE_N_CLASSES-1] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    // ----------------------------------------------------------
    // Tunes

    localparam step_t STEP_DONE = 4'hf;

    localparam note_t SONG_NOTES [0:`NOTE_N_SONGS-1][0:SONG_LEN-1] = '{
        '{NOTE_BF, NOTE_D,  NOTE_BF, NOTE_D,  NOTE_EF, NOTE_D,  NOTE_C,  NOTE_A,
          NOTE_C,  NOTE_A,  NOTE_C,  NOTE_D,  NOTE_C,  NOTE_BF, NOTE_G},
        '{NOTE_G,  NOTE_C,  NOTE_EF, NOTE_D,  NOTE_C,  NOTE_EF, NOTE_C,  NOTE_D,
          NOTE_C,  NOTE_AF, NOTE_BF, NOTE_G,  NOTE_C,  NOTE_EF, NOTE_D}
    };

    function automatic note_t song_note(input int song, input step_t step);
        if (step == STEP_DONE)
            return NOTE_NONE;  // Nothing more to match
        return SONG_NOTES[song][step];
    endfunction

    // ----------------------------------------------------------
    // Segment glyphs

    localparam seg_t SEG_NOTE [0:NOTE_N_CLASSES-1] = '{
        8'b10011100, 8'b10011101, 8'b01111010, 8'b01111011,  // C C# D D#
        8'b10011110, 8'b10001110, 8'b10001111, 8'b10111100,  // E F F# G
        8'b10111101, 8'b11101110, 8'b11101111, 8'b00111110   // G# A A# B
    };

    localparam seg_t SEG_HEX [0:SONG_LEN-1] = '{
        8'b11111100, 8'b01100000, 8'b11011010, 8'b11110010, 8'b01100110,
        8'b10110110, 8'b10111110, 8'b11100000, 8'b11111110, 8'b11100110,
        8'b11101110, 8'b00111110, 8'b10011100, 8'b01111010, 8'b10011110
    };

    localparam seg_t SEG_DONE  = 8'b11000110;  // Small raised o
    localparam seg_t SEG_DASH  = 8'b00000010;
    localparam seg_t SEG_BLANK = 8'b00000000;

endpackage

// File: common/note_config.svh
`ifndef NOTE_CONFIG_SVH
`define NOTE_CONFIG_SVH

// Project clock in Hz
`define NOTE_CLK_HZ     1000000

// Accepted period band in percent of nominal
`define NOTE_TOL_LOW    97
`define NOTE_TOL_HIGH   103

`define NOTE_MIC_W      24   // Signed microphone sample
`define NOTE_PERIOD_W   20   // Period counter, saturates on silence

// A note is kept once the stability counter fills
`define NOTE_STABLE_W   12

// One digit step per 2**NOTE_SCAN_W cycles
`define NOTE_SCAN_W     4

`define NOTE_N_SONGS    2

`endif
